//--- logic/amo_mem_cfg.svh
`ifndef AMO_MEM_CFG_SVH
`define AMO_MEM_CFG_SVH

// Bank count must be a power of two
`define AMO_NUM_BANKS 4
`define AMO_BANK_ROWS 64
`define AMO_ADDR_W 11

`define AMO_REG_ADDR 8'h00
`define AMO_REG_WDATA_LO 8'h04
`define AMO_REG_WDATA_HI 8'h08
`define AMO_REG_CMD 8'h0C
`define AMO_REG_RDATA_LO 8'h10
`define AMO_REG_RDATA_HI 8'h14

`endif

//--- logic/amo_mem_pkg.sv
`default_nettype none

package amo_mem_pkg;

  typedef enum logic [4:0] {
    LB        = 5'd0,
    LBU       = 5'd1,
    LH        = 5'd2,
    LHU       = 5'd3,
    LW        = 5'd4,
    LWU       = 5'd5,
    LD        = 5'd6,
    SB        = 5'd7,
    SH        = 5'd8,
    SW        = 5'd9,
    SD        = 5'd10,
    AMOSWAP_W = 5'd11,
    AMOSWAP_D = 5'd12,
    AMOADD_W  = 5'd13,
    AMOADD_D  = 5'd14,
    AMOXOR_W  = 5'd15,
    AMOXOR_D  = 5'd16,
    AMOAND_W  = 5'd17,
    AMOAND_D  = 5'd18,
    AMOOR_W   = 5'd19,
    AMOOR_D   = 5'd20,
    AMOMIN_W  = 5'd21,
    AMOMIN_D  = 5'd22,
    AMOMAX_W  = 5'd23,
    AMOMAX_D  = 5'd24,
    AMOMINU_W = 5'd25,
    AMOMINU_D = 5'd26,
    AMOMAXU_W = 5'd27,
    AMOMAXU_D = 5'd28
  } amo_op_e;

  typedef enum logic [1:0] {
    SZ_BYTE   = 2'd0,
    SZ_HALF   = 2'd1,
    SZ_WORD   = 2'd2,
    SZ_DOUBLE = 2'd3
  } amo_size_e;

  // Doubleword seen whole or as its two 32-bit halves
  typedef union packed {
    logic [63:0]      dword;
    logic [1:0][31:0] word;
  } amo_lane_u;

endpackage

`default_nettype wire

//--- logic/amo_apb_front.sv
`timescale 1ns/1ps
`default_nettype none
`include "amo_mem_cfg.svh"

module amo_apb_front (
  input  wire                    clk_i,
  input  wire                    reset_i,
  input  wire                    psel_i,
  input  wire                    penable_i,
  input  wire                    pwrite_i,
  input  wire  [7:0]             paddr_i,
  input  wire  [31:0]            pwdata_i,
  output logic [31:0]            prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  output logic                   cmd_valid_o,
  output amo_mem_pkg::amo_op_e   cmd_op_o,
  output logic [`AMO_ADDR_W-1:0] cmd_addr_o,
  output logic [63:0]            cmd_wdata_o,
  input  wire                    done_i,
  input  wire  [63:0]            rdata_i
);

  logic                   access;
  logic                   wr_en;
  logic                   is_cmd;
  logic                   op_ok;
  logic                   mapped;
  logic                   launch;
  logic                   busy_q;
  logic                   fin_q;
  logic [`AMO_ADDR_W-1:0] addr_q;
  amo_mem_pkg::amo_lane_u wdata_q;
  amo_mem_pkg::amo_lane_u rdata_q;
  amo_mem_pkg::amo_op_e   cmd_q;

  assign access = psel_i && penable_i;
  assign is_cmd = (paddr_i == `AMO_REG_CMD);
  assign op_ok  = (pwdata_i[31:5] == '0) && (pwdata_i[4:0] <= 5'(amo_mem_pkg::AMOMAXU_D));
  assign mapped = paddr_i inside {`AMO_REG_ADDR, `AMO_REG_WDATA_LO, `AMO_REG_WDATA_HI,
                                  `AMO_REG_CMD, `AMO_REG_RDATA_LO, `AMO_REG_RDATA_HI};

  // fin_q marks the cycle the stalled command write may finally complete
  assign launch    = access && pwrite_i && is_cmd && op_ok && !busy_q && !fin_q;
  assign pready_o  = !busy_q && !launch;
  assign pslverr_o = access && pready_o && (!mapped || (pwrite_i && is_cmd && !op_ok));
  assign wr_en     = access && pwrite_i && pready_o;

  assign cmd_valid_o = launch;
  assign cmd_op_o    = amo_mem_pkg::amo_op_e'(pwdata_i[4:0]);
  assign cmd_addr_o  = addr_q;
  assign cmd_wdata_o = wdata_q.dword;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      fin_q  <= 1'b0;
    end else begin
      if (launch) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
      if (done_i) begin
        fin_q <= 1'b1;
      end else if (access && pready_o) begin
        fin_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en && (paddr_i == `AMO_REG_ADDR)) begin
      addr_q <= pwdata_i[`AMO_ADDR_W-1:0];
    end
    if (wr_en && (paddr_i == `AMO_REG_WDATA_LO)) begin
      wdata_q.word[0] <= pwdata_i;
    end
    if (wr_en && (paddr_i == `AMO_REG_WDATA_HI)) begin
      wdata_q.word[1] <= pwdata_i;
    end
    if (launch) begin
      cmd_q <= amo_mem_pkg::amo_op_e'(pwdata_i[4:0]);
    end
    if (done_i) begin
      rdata_q.dword <= rdata_i;
    end
  end

  always_comb begin
    case (paddr_i)
      `AMO_REG_ADDR:     prdata_o = 32'(addr_q);
      `AMO_REG_WDATA_LO: prdata_o = wdata_q.word[0];
      `AMO_REG_WDATA_HI: prdata_o = wdata_q.word[1];
      `AMO_REG_CMD:      prdata_o = 32'(cmd_q);
      `AMO_REG_RDATA_LO: prdata_o = rdata_q.word[0];
      `AMO_REG_RDATA_HI: prdata_o = rdata_q.word[1];
      default:           prdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/amo_bank_dispatch.sv
`timescale 1ns/1ps
`default_nettype none
`include "amo_mem_cfg.svh"

module amo_bank_dispatch (
  input  wire                                clk_i,
  input  wire                                reset_i,
  input  wire                                cmd_valid_i,
  input  var   amo_mem_pkg::amo_op_e         cmd_op_i,
  input  wire  [`AMO_ADDR_W-1:0]             cmd_addr_i,
  input  wire  [63:0]                        cmd_wdata_i,
  output logic [`AMO_NUM_BANKS-1:0]          bank_req_o,
  output amo_mem_pkg::amo_op_e               op_o,
  output amo_mem_pkg::amo_size_e             size_o,
  output logic [$clog2(`AMO_BANK_ROWS)-1:0]  row_o,
  output logic [2:0]                         offset_o,
  output logic [63:0]                        wdata_o
);

  localparam int BANK_W = $clog2(`AMO_NUM_BANKS);
  localparam int ROW_W  = $clog2(`AMO_BANK_ROWS);

  logic [BANK_W-1:0]         bank_sel;
  logic [`AMO_NUM_BANKS-1:0] req_d;
  amo_mem_pkg::amo_size_e    size_d;

  // Doubleword interleave: offset, then bank, then row
  assign bank_sel = cmd_addr_i[3 +: BANK_W];

  always_comb begin
    for (int i = 0; i < `AMO_NUM_BANKS; i++) begin
      req_d[i] = cmd_valid_i && (bank_sel == BANK_W'(i));
    end
  end

  always_comb begin
    case (cmd_op_i)
      amo_mem_pkg::LB, amo_mem_pkg::LBU, amo_mem_pkg::SB: size_d = amo_mem_pkg::SZ_BYTE;
      amo_mem_pkg::LH, amo_mem_pkg::LHU, amo_mem_pkg::SH: size_d = amo_mem_pkg::SZ_HALF;
      amo_mem_pkg::LW, amo_mem_pkg::LWU, amo_mem_pkg::SW,
      amo_mem_pkg::AMOSWAP_W, amo_mem_pkg::AMOADD_W, amo_mem_pkg::AMOXOR_W,
      amo_mem_pkg::AMOAND_W, amo_mem_pkg::AMOOR_W, amo_mem_pkg::AMOMIN_W,
      amo_mem_pkg::AMOMAX_W, amo_mem_pkg::AMOMINU_W,
      amo_mem_pkg::AMOMAXU_W: size_d = amo_mem_pkg::SZ_WORD;
      default: size_d = amo_mem_pkg::SZ_DOUBLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bank_req_o <= '0;
    end else begin
      bank_req_o <= req_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      op_o     <= cmd_op_i;
      size_o   <= size_d;
      row_o    <= cmd_addr_i[3+BANK_W +: ROW_W];
      offset_o <= cmd_addr_i[2:0];
      wdata_o  <= cmd_wdata_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/amo_bank.sv
`timescale 1ns/1ps
`default_nettype none
`include "amo_mem_cfg.svh"

module amo_bank (
  input  wire                               clk_i,
  input  wire                               reset_i,
  input  wire                               req_i,
  input  var   amo_mem_pkg::amo_op_e        op_i,
  input  var   amo_mem_pkg::amo_size_e      size_i,
  input  wire  [$clog2(`AMO_BANK_ROWS)-1:0] row_i,
  input  wire  [2:0]                        offset_i,
  input  wire  [63:0]                       wdata_i,
  output logic                              resp_valid_o,
  output logic [63:0]                       resp_data_o
);

  logic [63:0]            mem [`AMO_BANK_ROWS];
  amo_mem_pkg::amo_lane_u old_u;
  logic [7:0]             byte_sel;
  logic [15:0]            half_sel;
  logic [31:0]            word_sel;
  logic                   is_load;
  logic                   is_store;
  logic                   is_unsigned;
  logic [63:0]            load_ext;
  logic [63:0]            opnd_b;
  logic [63:0]            alu;
  logic [63:0]            rep;
  logic [7:0]             byte_mask;
  logic [63:0]            bit_mask;
  logic [63:0]            merged;

  always_comb begin
    old_u.dword = mem[row_i];
  end

  assign byte_sel = old_u.dword[{offset_i, 3'b000} +: 8];
  assign half_sel = old_u.dword[{offset_i[2:1], 4'b0000} +: 16];
  assign word_sel = old_u.word[offset_i[2]];

  always_comb begin
    is_load     = 1'b0;
    is_store    = 1'b0;
    is_unsigned = 1'b0;
    case (op_i)
      amo_mem_pkg::LBU, amo_mem_pkg::LHU, amo_mem_pkg::LWU: begin
        is_load     = 1'b1;
        is_unsigned = 1'b1;
      end
      amo_mem_pkg::LB, amo_mem_pkg::LH, amo_mem_pkg::LW, amo_mem_pkg::LD: is_load = 1'b1;
      amo_mem_pkg::SB, amo_mem_pkg::SH, amo_mem_pkg::SW, amo_mem_pkg::SD: is_store = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    case (size_i)
      amo_mem_pkg::SZ_BYTE: load_ext = {{56{byte_sel[7] & !is_unsigned}}, byte_sel};
      amo_mem_pkg::SZ_HALF: load_ext = {{48{half_sel[15] & !is_unsigned}}, half_sel};
      amo_mem_pkg::SZ_WORD: load_ext = {{32{word_sel[31] & !is_unsigned}}, word_sel};
      default:              load_ext = old_u.dword;
    endcase
  end

  // Sign extension keeps both signed and unsigned order, so one 64-bit ALU serves _W too
  assign opnd_b = (size_i == amo_mem_pkg::SZ_WORD) ? {{32{wdata_i[31]}}, wdata_i[31:0]}
                                                   : wdata_i;

  always_comb begin
    case (op_i)
      amo_mem_pkg::AMOADD_W, amo_mem_pkg::AMOADD_D: alu = load_ext + opnd_b;
      amo_mem_pkg::AMOXOR_W, amo_mem_pkg::AMOXOR_D: alu = load_ext ^ opnd_b;
      amo_mem_pkg::AMOAND_W, amo_mem_pkg::AMOAND_D: alu = load_ext & opnd_b;
      amo_mem_pkg::AMOOR_W, amo_mem_pkg::AMOOR_D:   alu = load_ext | opnd_b;
      amo_mem_pkg::AMOMIN_W, amo_mem_pkg::AMOMIN_D:
        alu = ($signed(opnd_b) < $signed(load_ext)) ? opnd_b : load_ext;
      amo_mem_pkg::AMOMAX_W, amo_mem_pkg::AMOMAX_D:
        alu = ($signed(opnd_b) > $signed(load_ext)) ? opnd_b : load_ext;
      amo_mem_pkg::AMOMINU_W, amo_mem_pkg::AMOMINU_D:
        alu = (opnd_b < load_ext) ? opnd_b : load_ext;
      amo_mem_pkg::AMOMAXU_W, amo_mem_pkg::AMOMAXU_D:
        alu = (opnd_b > load_ext) ? opnd_b : load_ext;
      // Stores and swaps
      default: alu = opnd_b;
    endcase
  end

  always_comb begin
    case (size_i)
      amo_mem_pkg::SZ_BYTE: begin
        rep       = {8{alu[7:0]}};
        byte_mask = 8'h01 << offset_i;
      end
      amo_mem_pkg::SZ_HALF: begin
        rep       = {4{alu[15:0]}};
        byte_mask = 8'h03 << {offset_i[2:1], 1'b0};
      end
      amo_mem_pkg::SZ_WORD: begin
        rep       = {2{alu[31:0]}};
        byte_mask = 8'h0f << {offset_i[2], 2'b00};
      end
      default: begin
        rep       = alu;
        byte_mask = 8'hff;
      end
    endcase
  end

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      bit_mask[8*i +: 8] = {8{byte_mask[i]}};
    end
  end

  assign merged = (rep & bit_mask) | (old_u.dword & ~bit_mask);

  always_ff @(posedge clk_i) begin
    if (req_i && !is_load) begin
      mem[row_i] <= merged;
    end
    if (req_i) begin
      resp_data_o <= is_store ? 64'd0 : load_ext;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= req_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/amo_resp_collect.sv
`timescale 1ns/1ps
`default_nettype none
`include "amo_mem_cfg.svh"

module amo_resp_collect (
  input  wire                        clk_i,
  input  wire                        reset_i,
  input  wire  [`AMO_NUM_BANKS-1:0]  resp_valid_i,
  input  wire  [63:0]                resp_data_i [`AMO_NUM_BANKS],
  output logic                       done_o,
  output logic [63:0]                rdata_o
);

  logic        any_valid;
  logic [63:0] sel_data;

  assign any_valid = |resp_valid_i;

  // At most one bank answers, so an AND-OR mux is enough
  always_comb begin
    sel_data = '0;
    for (int i = 0; i < `AMO_NUM_BANKS; i++) begin
      sel_data = sel_data | (resp_data_i[i] & {64{resp_valid_i[i]}});
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= any_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (any_valid) begin
      rdata_o <= sel_data;
    end
  end

endmodule

`default_nettype wire

//--- logic/amo_mem_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "amo_mem_cfg.svh"

module amo_mem_top (
  input  wire         clk_i,
  input  wire         reset_i,
  input  wire         psel_i,
  input  wire         penable_i,
  input  wire         pwrite_i,
  input  wire  [7:0]  paddr_i,
  input  wire  [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o
);

  logic                              cmd_valid;
  amo_mem_pkg::amo_op_e              cmd_op;
  logic [`AMO_ADDR_W-1:0]            cmd_addr;
  logic [63:0]                       cmd_wdata;
  logic                              done;
  logic [63:0]                       rdata;
  logic [`AMO_NUM_BANKS-1:0]         bank_req;
  amo_mem_pkg::amo_op_e              op;
  amo_mem_pkg::amo_size_e            size;
  logic [$clog2(`AMO_BANK_ROWS)-1:0] row;
  logic [2:0]                        offset;
  logic [63:0]                       wdata;
  logic [`AMO_NUM_BANKS-1:0]         resp_valid;
  logic [63:0]                       resp_data [`AMO_NUM_BANKS];

  amo_apb_front u_front (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .cmd_valid_o (cmd_valid),
    .cmd_op_o    (cmd_op),
    .cmd_addr_o  (cmd_addr),
    .cmd_wdata_o (cmd_wdata),
    .done_i      (done),
    .rdata_i     (rdata)
  );

  amo_bank_dispatch u_dispatch (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_valid_i (cmd_valid),
    .cmd_op_i    (cmd_op),
    .cmd_addr_i  (cmd_addr),
    .cmd_wdata_i (cmd_wdata),
    .bank_req_o  (bank_req),
    .op_o        (op),
    .size_o      (size),
    .row_o       (row),
    .offset_o    (offset),
    .wdata_o     (wdata)
  );

  // Shared request fields fan out, only the request bit is per bank
  for (genvar g = 0; g < `AMO_NUM_BANKS; g++) begin : g_bank
    amo_bank u_bank (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .req_i        (bank_req[g]),
      .op_i         (op),
      .size_i       (size),
      .row_i        (row),
      .offset_i     (offset),
      .wdata_i      (wdata),
      .resp_valid_o (resp_valid[g]),
      .resp_data_o  (resp_data[g])
    );
  end

  amo_resp_collect u_collect (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .resp_valid_i (resp_valid),
    .resp_data_i  (resp_data),
    .done_o       (done),
    .rdata_o      (rdata)
  );

endmodule

`default_nettype wire

//--- bench/amo_mem_tests.svh
`ifndef AMO_MEM_TESTS_SVH
`define AMO_MEM_TESTS_SVH

  task automatic test_store_load();
    logic [5:0]  row;
    logic [63:0] data;
    // Fill pattern depends on every doubleword address bit
    for (int i = 0; i < 256; i++) begin
      data = {32'h9e37_79b9 * 32'(i + 1), 24'hc3_a5e1, 8'(i)};
      run_cmd(amo_mem_pkg::SD, {8'(i), 3'b000}, data);
    end
    for (int i = 0; i < 256; i++) begin
      run_cmd(amo_mem_pkg::LD, {8'(i), 3'b000}, 64'd0);
    end
    // Same row in every bank
    row = 6'($urandom);
    for (int b = 0; b < `AMO_NUM_BANKS; b++) begin
      run_cmd(amo_mem_pkg::SD, {row, 2'(b), 3'b000}, {$urandom, $urandom});
    end
    for (int b = 0; b < `AMO_NUM_BANKS; b++) begin
      run_cmd(amo_mem_pkg::LD, {row, 2'(b), 3'($urandom)}, 64'd0);
    end
  endtask

  task automatic test_subword();
    logic [7:0]  dw;
    logic [63:0] data;
    dw = 8'($urandom);
    for (int off = 0; off < 8; off++) begin
      data    = {$urandom, $urandom};
      data[7] = off[0];
      run_cmd(amo_mem_pkg::SB, {dw, 3'(off)}, data);
      run_cmd(amo_mem_pkg::LB, {dw, 3'(off)}, 64'd0);
      run_cmd(amo_mem_pkg::LBU, {dw, 3'(off)}, 64'd0);
      run_cmd(amo_mem_pkg::LD, {dw, 3'b000}, 64'd0);
    end
    for (int off = 0; off < 8; off += 2) begin
      data     = {$urandom, $urandom};
      data[15] = off[1];
      run_cmd(amo_mem_pkg::SH, {dw, 3'(off)}, data);
      run_cmd(amo_mem_pkg::LH, {dw, 3'(off)}, 64'd0);
      run_cmd(amo_mem_pkg::LHU, {dw, 3'(off)}, 64'd0);
      run_cmd(amo_mem_pkg::LD, {dw, 3'b000}, 64'd0);
    end
    for (int off = 0; off < 8; off += 4) begin
      data     = {$urandom, $urandom};
      data[31] = off[2];
      run_cmd(amo_mem_pkg::SW, {dw, 3'(off)}, data);
      run_cmd(amo_mem_pkg::LW, {dw, 3'(off)}, 64'd0);
      run_cmd(amo_mem_pkg::LWU, {dw, 3'(off)}, 64'd0);
      run_cmd(amo_mem_pkg::LD, {dw, 3'b000}, 64'd0);
    end
  endtask

  task automatic test_amo_word();
    amo_mem_pkg::amo_op_e ops [9];
    logic [7:0]           dw;
    ops = '{amo_mem_pkg::AMOSWAP_W, amo_mem_pkg::AMOADD_W, amo_mem_pkg::AMOXOR_W,
            amo_mem_pkg::AMOAND_W, amo_mem_pkg::AMOOR_W, amo_mem_pkg::AMOMIN_W,
            amo_mem_pkg::AMOMAX_W, amo_mem_pkg::AMOMINU_W, amo_mem_pkg::AMOMAXU_W};
    for (int i = 0; i < 9; i++) begin
      dw = 8'($urandom);
      // Negative old word against a positive operand splits signed from unsigned order
      if (i[0]) begin
        run_cmd(amo_mem_pkg::SD, {dw, 3'b000}, {32'h8000_1234, $urandom});
      end else begin
        run_cmd(amo_mem_pkg::SD, {dw, 3'b000}, {$urandom, 32'h8000_1234});
      end
      run_cmd(ops[i], {dw, i[0], 2'b00}, {$urandom, 32'h0000_7fff});
      run_cmd(amo_mem_pkg::LD, {dw, 3'b000}, 64'd0);
    end
  endtask

  task automatic test_amo_double();
    amo_mem_pkg::amo_op_e ops [9];
    logic [7:0]           dw;
    ops = '{amo_mem_pkg::AMOSWAP_D, amo_mem_pkg::AMOADD_D, amo_mem_pkg::AMOXOR_D,
            amo_mem_pkg::AMOAND_D, amo_mem_pkg::AMOOR_D, amo_mem_pkg::AMOMIN_D,
            amo_mem_pkg::AMOMAX_D, amo_mem_pkg::AMOMINU_D, amo_mem_pkg::AMOMAXU_D};
    for (int i = 0; i < 9; i++) begin
      dw = 8'($urandom);
      // Low word all ones so AMOADD_D carries into the high word
      run_cmd(amo_mem_pkg::SD, {dw, 3'b000}, 64'h8000_0001_ffff_ffff);
      run_cmd(ops[i], {dw, 3'b000}, 64'h0000_0000_0000_0001);
      run_cmd(amo_mem_pkg::LD, {dw, 3'b000}, 64'd0);
    end
  endtask

  task automatic test_errors();
    logic        err;
    logic [31:0] rd;
    logic [10:0] addr;
    addr = {8'($urandom), 3'b000};
    run_cmd(amo_mem_pkg::SD, addr, 64'h0123_4567_89ab_cdef);
    apb_write(`AMO_REG_ADDR, 32'(addr), err);
    apb_write(`AMO_REG_WDATA_LO, 32'hdead_beef, err);
    apb_write(`AMO_REG_WDATA_HI, 32'hfeed_f00d, err);
    apb_write(`AMO_REG_CMD, 32'd29, err);
    check_value("pslverr for opcode 29", 64'd1, 64'(err));
    // Low bits encode SD but bit 5 makes it invalid
    apb_write(`AMO_REG_CMD, 32'h0000_002a, err);
    check_value("pslverr for opcode 0x2a", 64'd1, 64'(err));
    apb_read(8'h18, rd, err);
    check_value("pslverr for read at 0x18", 64'd1, 64'(err));
    apb_read(8'h40, rd, err);
    check_value("pslverr for read at 0x40", 64'd1, 64'(err));
    run_cmd(amo_mem_pkg::LD, addr, 64'd0);
  endtask

  task automatic test_registers();
    logic        err;
    logic [31:0] rd;
    logic [31:0] val;
    val = {21'd0, 11'($urandom)};
    apb_write(`AMO_REG_ADDR, val, err);
    apb_read(`AMO_REG_ADDR, rd, err);
    check_value("address register", 64'(val), 64'(rd));
    val = $urandom;
    apb_write(`AMO_REG_WDATA_LO, val, err);
    apb_read(`AMO_REG_WDATA_LO, rd, err);
    check_value("write data low register", 64'(val), 64'(rd));
    val = $urandom;
    apb_write(`AMO_REG_WDATA_HI, val, err);
    apb_read(`AMO_REG_WDATA_HI, rd, err);
    check_value("write data high register", 64'(val), 64'(rd));
  endtask

  task automatic test_random_mix();
    amo_mem_pkg::amo_op_e op;
    for (int n = 0; n < 200; n++) begin
      op = amo_mem_pkg::amo_op_e'(5'($urandom % 29));
      run_cmd(op, 11'($urandom), {$urandom, $urandom});
    end
  endtask

`endif

//--- bench/amo_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "amo_mem_cfg.svh"

module amo_mem_tb;

  localparam int WAIT_LIMIT = 50;

  logic        clk;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  // Expected contents, one entry per doubleword address
  logic [63:0] model_mem [256];

  amo_mem_top dut (
    .clk_i     (clk),
    .reset_i   (reset),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  always #4 clk = ~clk;

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s expected %h got %h", $time, what, exp, got);
      $display("=== FAIL ===");
      $fatal(1, "value check failed");
    end
  endtask

  // Access phase until pready, looked at mid-cycle, then back to idle on the falling edge
  task automatic finish_transfer(output logic [31:0] rd, output logic err);
    int cycles;
    cycles = 0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    while (!pready && cycles < WAIT_LIMIT) begin
      cycles++;
      @(negedge clk);
    end
    assert (pready) else begin
      $display("APB transfer to offset %h timed out waiting for pready", paddr);
      $display("=== FAIL ===");
      $fatal(1, "APB timeout");
    end
    rd  = prdata;
    err = pslverr;
    // The transfer completes on the rising edge before this one
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused_rd;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    finish_transfer(unused_rd, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    finish_transfer(data, err);
  endtask

  task automatic do_cmd(input amo_mem_pkg::amo_op_e op, input logic [10:0] addr,
                        input logic [63:0] wd, output logic [63:0] rd, output logic err);
    logic [31:0] lo;
    logic [31:0] hi;
    logic [5:0]  errs;
    apb_write(`AMO_REG_ADDR, 32'(addr), errs[0]);
    apb_write(`AMO_REG_WDATA_LO, wd[31:0], errs[1]);
    apb_write(`AMO_REG_WDATA_HI, wd[63:32], errs[2]);
    apb_write(`AMO_REG_CMD, 32'(op), errs[3]);
    apb_read(`AMO_REG_RDATA_LO, lo, errs[4]);
    apb_read(`AMO_REG_RDATA_HI, hi, errs[5]);
    rd  = {hi, lo};
    err = |errs;
  endtask

  function automatic int op_bytes(input amo_mem_pkg::amo_op_e op);
    case (op)
      amo_mem_pkg::LB, amo_mem_pkg::LBU, amo_mem_pkg::SB: return 1;
      amo_mem_pkg::LH, amo_mem_pkg::LHU, amo_mem_pkg::SH: return 2;
      amo_mem_pkg::LD, amo_mem_pkg::SD, amo_mem_pkg::AMOSWAP_D, amo_mem_pkg::AMOADD_D,
      amo_mem_pkg::AMOXOR_D, amo_mem_pkg::AMOAND_D, amo_mem_pkg::AMOOR_D,
      amo_mem_pkg::AMOMIN_D, amo_mem_pkg::AMOMAX_D, amo_mem_pkg::AMOMINU_D,
      amo_mem_pkg::AMOMAXU_D: return 8;
      default: return 4;
    endcase
  endfunction

  // New lane value from old lane a and operand b, compared on 32 or 64 bits
  function automatic logic [63:0] amo_result(input amo_mem_pkg::amo_op_e op,
                                             input logic [63:0] a, input logic [63:0] b,
                                             input bit word);
    logic lt_s;
    logic lt_u;
    if (word) begin
      lt_s = $signed(a[31:0]) < $signed(b[31:0]);
      lt_u = a[31:0] < b[31:0];
    end else begin
      lt_s = $signed(a) < $signed(b);
      lt_u = a < b;
    end
    case (op)
      amo_mem_pkg::AMOADD_W, amo_mem_pkg::AMOADD_D:   return a + b;
      amo_mem_pkg::AMOXOR_W, amo_mem_pkg::AMOXOR_D:   return a ^ b;
      amo_mem_pkg::AMOAND_W, amo_mem_pkg::AMOAND_D:   return a & b;
      amo_mem_pkg::AMOOR_W, amo_mem_pkg::AMOOR_D:     return a | b;
      amo_mem_pkg::AMOMIN_W, amo_mem_pkg::AMOMIN_D:   return lt_s ? a : b;
      amo_mem_pkg::AMOMAX_W, amo_mem_pkg::AMOMAX_D:   return lt_s ? b : a;
      amo_mem_pkg::AMOMINU_W, amo_mem_pkg::AMOMINU_D: return lt_u ? a : b;
      amo_mem_pkg::AMOMAXU_W, amo_mem_pkg::AMOMAXU_D: return lt_u ? b : a;
      default:                                        return b;
    endcase
  endfunction

  task automatic model_cmd(input amo_mem_pkg::amo_op_e op, input logic [10:0] addr,
                           input logic [63:0] wd, output logic [63:0] resp);
    int          nbytes;
    int          shift;
    logic [63:0] mask;
    logic [63:0] old_dw;
    logic [63:0] lane;
    logic [63:0] lane_new;
    nbytes = op_bytes(op);
    shift  = 8 * (int'(addr[2:0]) & ~(nbytes - 1));
    mask   = (nbytes == 8) ? {64{1'b1}} : ((64'd1 << (8 * nbytes)) - 64'd1);
    old_dw = model_mem[addr[10:3]];
    lane   = (old_dw >> shift) & mask;
    if (op inside {amo_mem_pkg::LBU, amo_mem_pkg::LHU, amo_mem_pkg::LWU} ||
        !lane[6'(8 * nbytes - 1)]) begin
      resp = lane;
    end else begin
      resp = lane | ~mask;
    end
    if (op >= amo_mem_pkg::SB && op <= amo_mem_pkg::SD) begin
      lane_new = wd;
      resp     = 64'd0;
    end else begin
      lane_new = amo_result(op, lane, wd, nbytes == 4);
    end
    if (op > amo_mem_pkg::LD) begin
      model_mem[addr[10:3]] = (old_dw & ~(mask << shift)) | ((lane_new & mask) << shift);
    end
  endtask

  task automatic run_cmd(input amo_mem_pkg::amo_op_e op, input logic [10:0] addr,
                         input logic [63:0] wd);
    logic [63:0] exp;
    logic [63:0] got;
    logic        err;
    model_cmd(op, addr, wd, exp);
    do_cmd(op, addr, wd, got, err);
    check_value($sformatf("pslverr on %s at %h", op.name(), addr), 64'd0, 64'(err));
    check_value($sformatf("%s at %h", op.name(), addr), exp, got);
  endtask

`include "amo_mem_tests.svh"

  initial begin
    void'($urandom(79));
    clk     = 1'b0;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_store_load();
    test_subword();
    test_amo_word();
    test_amo_double();
    test_errors();
    test_registers();
    test_random_mix();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+logic
+incdir+bench
logic/amo_mem_pkg.sv
logic/amo_apb_front.sv
logic/amo_bank_dispatch.sv
logic/amo_bank.sv
logic/amo_resp_collect.sv
logic/amo_mem_top.sv
bench/amo_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module amo_mem_tb -f build.f -o amo_mem_sim || exit 1
out="$(./obj_dir/amo_mem_sim 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx '=== PASS ===' && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
